// ==== alu_cc_unit.sv ====
module alu_cc_unit (
	input  logic                  clock_50,
	input  logic                  arst_n,
	input  datapath_pkg::word_t   bus_a,
	input  datapath_pkg::word_t   bus_b,
	input  datapath_pkg::alu_op_t alu_op,
	output datapath_pkg::word_t   bus_c,
	output logic                  flag_n,
	output logic                  flag_z,
	output logic                  flag_v,
	output logic                  flag_c
);

	import datapath_pkg::*;

	// 33-bit adder output, the top bit is the carry out of bit 31
	logic [32:0] sum;

	// flags as the current operation would set them
	logic cand_n;
	logic cand_z;
	logic cand_v;
	logic cand_c;

	// high for andcc, orcc, orncc and addcc
	logic cc_op;

	// --------------------
	// alu
	// --------------------

	// the adder is shared by add and addcc so the carry is always at hand
	assign sum = {1'b0, bus_a} + {1'b0, bus_b};

	always_comb begin
		case (alu_op)
			ALU_ANDCC, ALU_AND: bus_c = bus_a & bus_b;
			ALU_ORCC, ALU_OR:   bus_c = bus_a | bus_b;
			// or with the complement of b, as in the sparc orn
			ALU_ORNCC:          bus_c = bus_a | ~bus_b;
			ALU_ADDCC, ALU_ADD: bus_c = sum[31:0];
			ALU_XOR:            bus_c = bus_a ^ bus_b;
			ALU_SUB:            bus_c = bus_a - bus_b;
			ALU_PASS_A:         bus_c = bus_a;
			ALU_PASS_B:         bus_c = bus_b;
			// the spare codes put zero on the bus
			default:            bus_c = '0;
		endcase
	end

	// --------------------
	// condition codes
	// --------------------

	// the psr only listens to codes 0 to 3
	assign cc_op = (alu_op[3:2] == 2'b00);

	// n and z follow the result for every cc operation
	assign cand_n = bus_c[31];
	assign cand_z = (bus_c == '0);

	// overflow when both operands share a sign and the sum does not
	// the logical cc operations leave v and c at zero
	assign cand_v = (alu_op == ALU_ADDCC) &&
		(bus_a[31] == bus_b[31]) && (sum[31] != bus_a[31]);
	assign cand_c = (alu_op == ALU_ADDCC) && sum[32];

	// psr flags, loaded together at the edge that ends a cc operation
	always_ff @(posedge clock_50 or negedge arst_n) begin
		if (!arst_n) begin
			flag_n <= 1'b0;
			flag_z <= 1'b0;
			flag_v <= 1'b0;
			flag_c <= 1'b0;
		end else if (cc_op) begin
			flag_n <= cand_n;
			flag_z <= cand_z;
			flag_v <= cand_v;
			flag_c <= cand_c;
		end
	end

	// --------------------
	// assertions
	// --------------------

	// a plain alu operation on one edge must leave the psr as it was,
	// checked one edge later against what the flags were before
	a_flags_hold: assert property (
		@(posedge clock_50) disable iff (!arst_n)
		!$past(cc_op) |-> $stable({flag_n, flag_z, flag_v, flag_c})
	) else $error("alu_cc_unit: flags changed on a non-cc operation");

endmodule

// ==== datapath_pkg.sv ====
package datapath_pkg;

	// --------------------
	// widths
	// --------------------

	// one word as carried on bus a, bus b and bus c
	typedef logic [31:0] word_t;

	// register number on the read and write selects
	// six bits cover the 38 registers with room to spare
	typedef logic [5:0] reg_sel_t;

	// --------------------
	// alu operations
	// --------------------

	// the four codes at the bottom are the ones that update the psr
	// so a flag write is simply alu_op[3:2] == 0
	// codes 11 to 15 are left open and drive zero on bus c
	typedef enum logic [3:0] {
		ALU_ANDCC  = 4'd0,
		ALU_ORCC   = 4'd1,
		ALU_ORNCC  = 4'd2,
		ALU_ADDCC  = 4'd3,
		ALU_AND    = 4'd4,
		ALU_OR     = 4'd5,
		ALU_XOR    = 4'd6,
		ALU_ADD    = 4'd7,
		ALU_SUB    = 4'd8,
		ALU_PASS_A = 4'd9,
		ALU_PASS_B = 4'd10
	} alu_op_t;

	// --------------------
	// register map
	// --------------------

	// r0 to r31 sit at their own numbers, pc follows them,
	// then the four scratch registers t0 to t3, and ir last
	localparam reg_sel_t REG_ZERO = 6'd0;
	localparam reg_sel_t REG_PC   = 6'd32;
	localparam reg_sel_t REG_T0   = 6'd33;
	localparam reg_sel_t REG_IR   = 6'd37;

	// anything at or above this reads as zero and is never written
	localparam int NUM_REGS = 38;

	// start address that pc takes while arst_n is low
	localparam word_t PC_RESET = 32'h0000_0800;

endpackage

// ==== micro_datapath.sv ====
module micro_datapath #(
	parameter datapath_pkg::word_t pc_reset = datapath_pkg::PC_RESET
) (
	input  logic                   clock_50,
	input  logic                   arst_n,
	input  datapath_pkg::reg_sel_t sel_a,
	input  datapath_pkg::reg_sel_t sel_b,
	input  datapath_pkg::reg_sel_t sel_c,
	input  datapath_pkg::alu_op_t  alu_op,
	output datapath_pkg::word_t    bus_c,
	output logic                   flag_n,
	output logic                   flag_z,
	output logic                   flag_v,
	output logic                   flag_c,
	output logic [1:0]             ir_op,
	output logic [4:0]             ir_rd,
	output logic [2:0]             ir_op2,
	output logic [5:0]             ir_op3,
	output logic [4:0]             ir_rs1,
	output logic                   ir_bit13,
	output logic [4:0]             ir_rs2
);

	import datapath_pkg::*;

	// the two read buses from the bank into the alu
	word_t bus_a;
	word_t bus_b;

	// --------------------
	// register bank
	// --------------------

	// bus c is both the top-level result and the write data of the bank
	register_file #(
		.pc_reset (pc_reset)
	) u_register_file (
		.clock_50 (clock_50),
		.arst_n   (arst_n),
		.sel_a    (sel_a),
		.sel_b    (sel_b),
		.sel_c    (sel_c),
		.bus_c    (bus_c),
		.bus_a    (bus_a),
		.bus_b    (bus_b),
		.ir_op    (ir_op),
		.ir_rd    (ir_rd),
		.ir_op2   (ir_op2),
		.ir_op3   (ir_op3),
		.ir_rs1   (ir_rs1),
		.ir_bit13 (ir_bit13),
		.ir_rs2   (ir_rs2)
	);

	// --------------------
	// alu and psr
	// --------------------

	alu_cc_unit u_alu_cc_unit (
		.clock_50 (clock_50),
		.arst_n   (arst_n),
		.bus_a    (bus_a),
		.bus_b    (bus_b),
		.alu_op   (alu_op),
		.bus_c    (bus_c),
		.flag_n   (flag_n),
		.flag_z   (flag_z),
		.flag_v   (flag_v),
		.flag_c   (flag_c)
	);

endmodule

// ==== register_file.sv ====
module register_file #(
	parameter datapath_pkg::word_t pc_reset = datapath_pkg::PC_RESET
) (
	input  logic                   clock_50,
	input  logic                   arst_n,
	input  datapath_pkg::reg_sel_t sel_a,
	input  datapath_pkg::reg_sel_t sel_b,
	input  datapath_pkg::reg_sel_t sel_c,
	input  datapath_pkg::word_t    bus_c,
	output datapath_pkg::word_t    bus_a,
	output datapath_pkg::word_t    bus_b,
	output logic [1:0]             ir_op,
	output logic [4:0]             ir_rd,
	output logic [2:0]             ir_op2,
	output logic [5:0]             ir_op3,
	output logic [4:0]             ir_rs1,
	output logic                   ir_bit13,
	output logic [4:0]             ir_rs2
);

	import datapath_pkg::*;

	// storage for r1 to ir
	// r0 has no flip-flops at all and only exists as the zero on the read side
	word_t regs [1:NUM_REGS-1];

	// one enable per writable register as decoded from sel_c
	logic [NUM_REGS-1:1] wr_en;

	// --------------------
	// write decode
	// --------------------

	// only one bit can match sel_c, so the result is one-hot or empty
	// a select of 0 has no bit to match, and neither has anything past ir
	always_comb begin
		wr_en = '0;
		for (int i = 1; i < NUM_REGS; i++) begin
			wr_en[i] = (sel_c == reg_sel_t'(i));
		end
	end

	// --------------------
	// register bank
	// --------------------

	// every register clears on reset except pc
	// pc goes to the start address so the first fetch has somewhere to point
	always_ff @(posedge clock_50 or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 1; i < NUM_REGS; i++) begin
				regs[i] <= (i == REG_PC) ? pc_reset : '0;
			end
		end else begin
			// bus c lands in the selected register at the edge, so the
			// new value shows on the read buses in the following cycle
			for (int i = 1; i < NUM_REGS; i++) begin
				if (wr_en[i]) begin
					regs[i] <= bus_c;
				end
			end
		end
	end

	// --------------------
	// read multiplexers
	// --------------------

	// both buses default to zero, which covers r0 and the unused
	// select codes without a separate case for either
	always_comb begin
		bus_a = '0;
		bus_b = '0;
		for (int i = 1; i < NUM_REGS; i++) begin
			if (sel_a == reg_sel_t'(i)) begin
				bus_a = regs[i];
			end
			if (sel_b == reg_sel_t'(i)) begin
				bus_b = regs[i];
			end
		end
	end

	// --------------------
	// ir field split
	// --------------------

	// sparc instruction layout taken straight from the ir contents
	// op2 and op3 overlap on purpose since the format decides which one counts
	assign ir_op    = regs[REG_IR][31:30];
	assign ir_rd    = regs[REG_IR][29:25];
	assign ir_op2   = regs[REG_IR][24:22];
	assign ir_op3   = regs[REG_IR][24:19];
	assign ir_rs1   = regs[REG_IR][18:14];
	assign ir_bit13 = regs[REG_IR][13];
	// only the low five bits of the immediate/rs2 field feed the control unit
	assign ir_rs2   = regs[REG_IR][4:0];

	// --------------------
	// assertions
	// --------------------

	// the decode must never load two registers from one bus c value
	a_write_onehot: assert property (
		@(posedge clock_50) disable iff (!arst_n)
		$onehot0(wr_en)
	) else $error("register_file: more than one write enable active");

	// r0 is hard zero on bus a however the bank was written before
	a_r0_reads_zero: assert property (
		@(posedge clock_50) disable iff (!arst_n)
		(sel_a == REG_ZERO) |-> (bus_a == '0)
	) else $error("register_file: r0 read as nonzero on bus a");

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the datapath and its testbench with verilator, run it, then judge the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_micro_datapath \
	-f sources.f -o tb_micro_datapath || { echo "verilator build failed"; exit 1; }
./obj_dir/tb_micro_datapath > sim.log 2>&1
cat sim.log
grep -q '\*\*\* FAILED \*\*\*' sim.log && { echo "simulation reported a failure"; exit 1; }
grep -q '\*\*\* PASSED \*\*\*' sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation finished clean"

// ==== sources.f ====
datapath_pkg.sv
register_file.sv
alu_cc_unit.sv
micro_datapath.sv
tb_micro_datapath.sv

// ==== tb_micro_datapath.sv ====
module tb_micro_datapath;

	import datapath_pkg::*;

	// start address handed to the dut
	// it differs from the package default so the parameter is seen to pass down
	localparam word_t PC_START = 32'h0000_0c40;
	localparam int RESET_LIMIT = 16;

	logic       clock_50;
	logic       arst_n;
	reg_sel_t   sel_a;
	reg_sel_t   sel_b;
	reg_sel_t   sel_c;
	alu_op_t    alu_op;
	word_t      bus_c;
	logic       flag_n, flag_z, flag_v, flag_c;
	logic [1:0] ir_op;
	logic [4:0] ir_rd;
	logic [2:0] ir_op2;
	logic [5:0] ir_op3;
	logic [4:0] ir_rs1;
	logic       ir_bit13;
	logic [4:0] ir_rs2;

	// dut outputs gathered into words for the compare task
	logic [31:0] flags_word;
	logic [31:0] ir_word;

	// the model bank and its psr as they stand after the last edge
	word_t model_regs [0:37];
	logic  m_n, m_z, m_v, m_c;
	int    checks;
	int    errors;

	assign flags_word = {28'd0, flag_n, flag_z, flag_v, flag_c};
	assign ir_word    = {5'd0, ir_op, ir_rd, ir_op2, ir_op3, ir_rs1, ir_bit13, ir_rs2};

	micro_datapath #(.pc_reset(PC_START)) DUT (.*);

	initial begin
		clock_50 = 1'b0;
		forever #2 clock_50 = ~clock_50;
	end

	// --------------------
	// model
	// --------------------

	// r0 and every code past ir read zero
	function automatic word_t model_read(input reg_sel_t sel);
		if (sel == 6'd0 || sel > 6'd37) begin
			return '0;
		end
		return model_regs[sel];
	endfunction

	function automatic word_t model_alu(input int code, input word_t a, input word_t b);
		case (code)
			0, 4:    return a & b;
			1, 5:    return a | b;
			2:       return a | ~b;
			3, 7:    return a + b;
			6:       return a ^ b;
			8:       return a - b;
			9:       return a;
			10:      return b;
			default: return '0;
		endcase
	endfunction

	// sparc fields side by side with op first and rs2 last
	function automatic logic [26:0] ir_split(input word_t w);
		return {w[31:30], w[29:25], w[24:22], w[24:19], w[18:14], w[13], w[4:0]};
	endfunction

	task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED at time %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	// one microinstruction whose inputs change on the falling edge
	// outputs are compared one time unit later, well before the rising edge that commits
	task automatic step(input int a, input int b, input int c, input int code);
		word_t  va;
		word_t  vb;
		word_t  res;
		longint exact;
		@(negedge clock_50);
		sel_a = reg_sel_t'(a);
		sel_b = reg_sel_t'(b);
		sel_c = reg_sel_t'(c);
		alu_op = alu_op_t'(4'(code));
		#1;
		va = model_read(reg_sel_t'(a));
		vb = model_read(reg_sel_t'(b));
		res = model_alu(code, va, vb);
		check_value("bus_c", bus_c, res);
		check_value("flags nzvc", flags_word, {28'd0, m_n, m_z, m_v, m_c});
		check_value("ir fields", ir_word, {5'd0, ir_split(model_regs[37])});
		// the psr follows only codes 0 to 3 and takes v and c only from addcc
		if (code < 4) begin
			m_n = res[31];
			m_z = (res == '0);
			// signed overflow means the exact sum does not fit in 32 bits
			exact = longint'($signed(va)) + longint'($signed(vb));
			m_v = (code == 3) && (exact != longint'($signed(res)));
			// an unsigned sum that wrapped is smaller than either operand
			m_c = (code == 3) && (res < va);
		end
		if (c > 0 && c < 38) begin
			model_regs[c] = res;
		end
	endtask

	// no path loads a constant, so a word is built bit by bit through the alu
	// t3 holds all ones from orncc, t2 holds one, and the target doubles and adds
	task automatic load_word(input int target, input word_t value);
		step(0, 0, 36, 2);
		step(0, 36, 35, 8);
		step(0, 0, target, 9);
		for (int i = 31; i >= 0; i--) begin
			step(target, target, target, 7);
			if (value[i]) begin
				step(target, 35, target, 7);
			end
		end
	endtask

	task automatic report(input string name, input int errors_before);
		if (errors == errors_before) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: %0d errors", name, errors - errors_before);
		end
	endtask

	// --------------------
	// test sequence
	// --------------------

	initial begin
		int    errors_before;
		int    wait_count;
		word_t word;
		void'($urandom(32'h83a72ba7));
		arst_n = 1'b0;
		sel_a = REG_PC;
		sel_b = '0;
		sel_c = '0;
		alu_op = ALU_PASS_A;
		checks = 0;
		errors = 0;
		for (int i = 0; i < 38; i++) begin
			model_regs[i] = '0;
		end
		model_regs[32] = PC_START;
		{m_n, m_z, m_v, m_c} = 4'b0000;
		repeat (5) @(posedge clock_50);
		@(negedge clock_50);
		arst_n = 1'b1;
		// pass_a of pc is on the inputs, so the start address marks the end of reset
		wait_count = 0;
		while (bus_c !== PC_START && wait_count < RESET_LIMIT) begin
			@(negedge clock_50);
			wait_count++;
		end
		if (bus_c !== PC_START) begin
			$display("timeout: pc never showed its start address after reset");
			$display("*** FAILED ***");
		end else begin
			errors_before = errors;
			for (int s = 0; s < 64; s++) begin
				step(s, 0, 0, 9);
			end
			report("reset values", errors_before);

			// writes land on random codes, out of range ones too, then the whole bank is swept
			errors_before = errors;
			for (int k = 0; k < 6; k++) begin
				load_word($urandom_range(34, 1), $urandom);
			end
			for (int k = 0; k < 100; k++) begin
				step($urandom_range(63, 0), $urandom_range(63, 0), $urandom_range(63, 0), 10);
				step($urandom_range(63, 0), 0, 0, 9);
			end
			for (int s = 0; s < 64; s++) begin
				step(s, 0, 0, 9);
			end
			report("random writes and reads", errors_before);

			errors_before = errors;
			for (int k = 0; k < 4; k++) begin
				load_word($urandom_range(34, 1), $urandom);
			end
			for (int k = 0; k < 80; k++) begin
				step($urandom_range(37, 0), $urandom_range(37, 0), $urandom_range(37, 0),
					$urandom_range(15, 4));
			end
			report("plain alu operations", errors_before);

			errors_before = errors;
			for (int k = 0; k < 4; k++) begin
				load_word($urandom_range(34, 1), $urandom);
			end
			for (int k = 0; k < 80; k++) begin
				step($urandom_range(37, 0), $urandom_range(37, 0), 0, $urandom_range(3, 0));
			end
			// addcc corner cases with the flags read in the cycle after the edge
			load_word(1, 32'h7fff_ffff);
			load_word(2, 32'h0000_0001);
			step(1, 2, 0, 3);
			step(0, 0, 0, 9);
			check_value("addcc overflow nzvc", flags_word, 32'h0000_000a);
			load_word(3, 32'hffff_ffff);
			load_word(4, 32'h0000_0001);
			step(3, 4, 0, 3);
			step(0, 0, 0, 9);
			check_value("addcc carry to zero nzvc", flags_word, 32'h0000_0005);
			load_word(5, 32'h8000_0000);
			step(5, 5, 0, 3);
			step(0, 0, 0, 9);
			check_value("addcc carry and overflow nzvc", flags_word, 32'h0000_0007);
			report("condition codes", errors_before);

			errors_before = errors;
			for (int k = 0; k < 6; k++) begin
				word = $urandom;
				load_word(37, word);
				step(0, 0, 0, 9);
				check_value("ir fields of written word", ir_word, {5'd0, ir_split(word)});
			end
			report("ir fields", errors_before);

			$display("summary: %0d checks, %0d errors", checks, errors);
			if (errors == 0) begin
				$display("*** PASSED ***");
			end else begin
				$display("*** FAILED ***");
			end
		end
		$finish;
	end

endmodule
